// File: isa_pkg.sv
package isa_pkg;

    typedef enum logic [5:0] {
        NOP   = 6'h00,
        MOV   = 6'h01,
        ADD   = 6'h02,
        SUB   = 6'h03,
        AND   = 6'h04,
        OR    = 6'h05,
        XOR   = 6'h06,
        SHL   = 6'h07,
        SHR   = 6'h08,
        CMP   = 6'h09,
        ADDS  = 6'h10, // Signed register ops.
        SUBS  = 6'h11,
        SHRS  = 6'h12,
        CMPS  = 6'h13,
        LUI   = 6'h20, // Immediate ops.
        MOVI  = 6'h21,
        ADDI  = 6'h22,
        ADDIS = 6'h23,
        CMPI  = 6'h24,
        JCC   = 6'h30, // Branches.
        BCC   = 6'h31,
        BCCI  = 6'h32
    } opcode_e;

    typedef enum logic [3:0] {
        RA = 4'h0, // Always.
        EQ = 4'h1,
        NE = 4'h2,
        LT = 4'h3, // Signed compares.
        GT = 4'h4,
        GE = 4'h5,
        LE = 4'h6,
        BT = 4'h7, // Unsigned compares.
        AT = 4'h8,
        BE = 4'h9,
        AE = 4'hA
    } cond_e;

    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

endpackage

// File: core_pkg.sv
package core_pkg;

    localparam int DATA_W = 32;
    localparam int IMM_W  = 16;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [31:0] addr_t;

    typedef logic [IMM_W-1:0] imm_t;

    typedef logic [3:0] flags_t; // Indexed by the isa_pkg flag positions.

    typedef enum logic {
        IDLE = 1'b0,
        ACK  = 1'b1
    } hs_state_e;

endpackage

// File: exec_ctrl.sv
`timescale 1ns/10ps

module exec_ctrl (
    input  logic iw_clk,
    input  logic iw_rst,
    input  logic req,
    output logic ack,
    output logic commit
);

    core_pkg::hs_state_e state;
    core_pkg::hs_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::IDLE: begin
                if (req) begin
                    state_next = core_pkg::ACK;
                end
            end
            core_pkg::ACK: begin
                if (!req) begin
                    state_next = core_pkg::IDLE; // Requester has released.
                end
            end
            default: begin
                state_next = core_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state <= core_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign commit = (state == core_pkg::IDLE) && req;
    assign ack    = (state == core_pkg::ACK);

    // The ack that rises always answers a request seen on the edge before.
    a_ack_needs_req: assert property (@(posedge iw_clk) disable iff (iw_rst)
        $rose(ack) |-> $past(req));

    a_commit_single: assert property (@(posedge iw_clk) disable iff (iw_rst)
        commit |=> !commit);

endmodule

// File: exec_regfile.sv
`timescale 1ns/10ps

module exec_regfile #(
    parameter int REG_COUNT = 16,
    localparam int IDX_W = $clog2(REG_COUNT)
) (
    input  logic             iw_clk,
    input  logic             iw_rst,
    input  logic [IDX_W-1:0] src_idx,
    input  logic [IDX_W-1:0] tgt_idx,
    output core_pkg::data_t  src_data,
    output core_pkg::data_t  tgt_data,
    input  logic             wr_en,
    input  core_pkg::data_t  wr_data,
    input  logic             commit
);

    core_pkg::data_t regs [REG_COUNT];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && wr_en) begin
            regs[tgt_idx] <= wr_data;
        end
    end

    assign src_data = regs[src_idx];
    assign tgt_data = regs[tgt_idx]; // Old value feeds the ALU in the commit cycle.

    a_wr_in_commit: assert property (@(posedge iw_clk) disable iff (iw_rst)
        wr_en |-> commit);

endmodule

// File: exec_operand.sv
`timescale 1ns/10ps

module exec_operand (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  isa_pkg::opcode_e  opc,
    input  core_pkg::imm_t    imm,
    input  core_pkg::data_t   src_data,
    input  core_pkg::data_t   tgt_data,
    input  logic              commit,
    output core_pkg::data_t   opnd_a,
    output core_pkg::data_t   opnd_b,
    output core_pkg::data_t   imm_s
);

    core_pkg::imm_t  upper;
    core_pkg::data_t imm_u;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            upper <= '0;
        end else if (commit && (opc == isa_pkg::LUI)) begin
            upper <= imm;
        end
    end

    assign imm_u = {upper, imm};
    assign imm_s = {{(core_pkg::DATA_W - core_pkg::IMM_W){imm[core_pkg::IMM_W-1]}}, imm};

    always_comb begin
        case (opc)
            isa_pkg::MOVI, isa_pkg::ADDI, isa_pkg::CMPI: begin
                opnd_a = imm_u;
            end
            isa_pkg::ADDIS, isa_pkg::BCCI: begin
                opnd_a = imm_s;
            end
            default: begin
                opnd_a = src_data; // Register ops and JCC/BCC.
            end
        endcase
    end

    assign opnd_b = tgt_data;

endmodule

// File: exec_alu.sv
`timescale 1ns/10ps

module exec_alu (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  isa_pkg::opcode_e  opc,
    input  core_pkg::data_t   opnd_a,
    input  core_pkg::data_t   opnd_b,
    input  logic              commit,
    output logic              wr_en,
    output core_pkg::data_t   wr_data,
    output core_pkg::flags_t  flags_next,
    output core_pkg::flags_t  flags_mask,
    output core_pkg::data_t   result
);

    localparam int MSB  = core_pkg::DATA_W - 1;
    localparam int SH_W = $clog2(core_pkg::DATA_W);

    logic [core_pkg::DATA_W:0] sum_w;
    core_pkg::data_t           diff;
    core_pkg::data_t           sra_v;
    logic [SH_W-1:0]           sh_amt;
    logic                      borrow;
    logic                      add_ovf;
    logic                      sub_ovf;
    logic                      big_shift;
    core_pkg::data_t           value;
    logic                      writes;
    core_pkg::data_t           result_q;

    assign sum_w     = {1'b0, opnd_b} + {1'b0, opnd_a};
    assign diff      = opnd_b - opnd_a;
    assign borrow    = opnd_b < opnd_a;
    assign sh_amt    = opnd_a[SH_W-1:0];
    assign big_shift = opnd_a >= core_pkg::data_t'(core_pkg::DATA_W);
    assign sra_v     = $signed(opnd_b) >>> sh_amt;

    // Signed overflow from the true sign bit.
    assign add_ovf = (opnd_a[MSB] == opnd_b[MSB]) && (sum_w[MSB] != opnd_b[MSB]);
    assign sub_ovf = (opnd_a[MSB] != opnd_b[MSB]) && (diff[MSB] != opnd_b[MSB]);

    always_comb begin
        value      = '0;
        writes     = 1'b0;
        flags_next = '0;
        flags_mask = '0;
        case (opc)
            isa_pkg::MOV, isa_pkg::MOVI: begin
                value  = opnd_a;
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
            end
            isa_pkg::ADD, isa_pkg::ADDI: begin
                value  = sum_w[MSB:0];
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_C] = 1'b1;
                flags_next[isa_pkg::FLAG_C] = sum_w[core_pkg::DATA_W]; // Carry out.
            end
            isa_pkg::SUB: begin
                value  = diff;
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_C] = 1'b1;
                flags_next[isa_pkg::FLAG_C] = borrow;
            end
            isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR: begin
                if (opc == isa_pkg::AND) begin
                    value = opnd_a & opnd_b;
                end else if (opc == isa_pkg::OR) begin
                    value = opnd_a | opnd_b;
                end else begin
                    value = opnd_a ^ opnd_b;
                end
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
            end
            isa_pkg::SHL, isa_pkg::SHR, isa_pkg::SHRS: begin
                if (big_shift) begin
                    value = '0;
                end else if (opc == isa_pkg::SHL) begin
                    value = opnd_b << sh_amt;
                end else if (opc == isa_pkg::SHR) begin
                    value = opnd_b >> sh_amt;
                end else begin
                    value = sra_v;
                end
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_V] = 1'b1;
                flags_mask[isa_pkg::FLAG_N] = (opc == isa_pkg::SHRS);
                flags_next[isa_pkg::FLAG_V] = big_shift;
            end
            isa_pkg::ADDS, isa_pkg::ADDIS: begin
                value  = sum_w[MSB:0];
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_N] = 1'b1;
                flags_mask[isa_pkg::FLAG_V] = 1'b1;
                flags_next[isa_pkg::FLAG_V] = add_ovf;
            end
            isa_pkg::SUBS: begin
                value  = diff;
                writes = 1'b1;
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_N] = 1'b1;
                flags_mask[isa_pkg::FLAG_V] = 1'b1;
                flags_next[isa_pkg::FLAG_V] = sub_ovf;
            end
            isa_pkg::CMP, isa_pkg::CMPI: begin
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_C] = 1'b1;
                flags_next[isa_pkg::FLAG_C] = borrow;
            end
            isa_pkg::CMPS: begin
                flags_mask[isa_pkg::FLAG_Z] = 1'b1;
                flags_mask[isa_pkg::FLAG_N] = 1'b1;
                flags_mask[isa_pkg::FLAG_V] = 1'b1;
                flags_next[isa_pkg::FLAG_V] = sub_ovf;
            end
            default: begin
            end
        endcase
        // Compares take Z and N from the difference, the rest from the value.
        flags_next[isa_pkg::FLAG_Z] = writes ? (value == '0) : (diff == '0);
        flags_next[isa_pkg::FLAG_N] = writes ? value[MSB] : diff[MSB];
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            result_q <= '0;
        end else if (commit) begin
            result_q <= value;
        end
    end

    assign wr_en   = commit && writes;
    assign wr_data = value;
    assign result  = result_q;

endmodule

// File: exec_cond.sv
`timescale 1ns/10ps

module exec_cond (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  isa_pkg::opcode_e  opc,
    input  isa_pkg::cond_e    cc,
    input  core_pkg::addr_t   pc,
    input  core_pkg::data_t   opnd_a,
    input  core_pkg::data_t   imm_s,
    input  core_pkg::flags_t  flags_next,
    input  core_pkg::flags_t  flags_mask,
    input  logic              commit,
    output core_pkg::flags_t  flags,
    output logic              branch_taken,
    output core_pkg::addr_t   branch_pc
);

    core_pkg::flags_t flags_q;
    logic             is_branch;
    logic             cond_true;
    logic             fz;
    logic             fn;
    logic             fc;
    logic             fv;
    core_pkg::addr_t  target;

    assign fz = flags_q[isa_pkg::FLAG_Z];
    assign fn = flags_q[isa_pkg::FLAG_N];
    assign fc = flags_q[isa_pkg::FLAG_C];
    assign fv = flags_q[isa_pkg::FLAG_V];

    assign is_branch = (opc == isa_pkg::JCC) || (opc == isa_pkg::BCC) || (opc == isa_pkg::BCCI);

    always_comb begin
        case (cc)
            isa_pkg::RA: cond_true = 1'b1;
            isa_pkg::EQ: cond_true = fz;
            isa_pkg::NE: cond_true = !fz;
            isa_pkg::LT: cond_true = fn ^ fv;
            isa_pkg::GT: cond_true = !fz && !(fn ^ fv);
            isa_pkg::GE: cond_true = !(fn ^ fv);
            isa_pkg::LE: cond_true = fz || (fn ^ fv);
            isa_pkg::BT: cond_true = fc;
            isa_pkg::AT: cond_true = !fz && !fc;
            isa_pkg::BE: cond_true = fc || fz;
            isa_pkg::AE: cond_true = !fc;
            default:     cond_true = 1'b0;
        endcase
    end

    always_comb begin
        case (opc)
            isa_pkg::JCC:  target = opnd_a; // Absolute.
            isa_pkg::BCC:  target = pc + opnd_a;
            isa_pkg::BCCI: target = pc + imm_s;
            default:       target = '0;
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            flags_q      <= '0;
            branch_taken <= 1'b0;
            branch_pc    <= '0;
        end else if (commit) begin
            flags_q      <= (flags_q & ~flags_mask) | (flags_next & flags_mask);
            branch_taken <= is_branch && cond_true;
            branch_pc    <= (is_branch && cond_true) ? target : '0;
        end
    end

    assign flags = flags_q;

    a_no_stray_taken: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (commit && !is_branch) |=> !branch_taken);

endmodule

// File: exec_top.sv
`timescale 1ns/10ps

module exec_top #(
    parameter int REG_COUNT = 16,
    localparam int IDX_W = $clog2(REG_COUNT)
) (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              req,
    input  isa_pkg::opcode_e  opc,
    input  isa_pkg::cond_e    cc,
    input  logic [IDX_W-1:0]  tgt,
    input  logic [IDX_W-1:0]  src,
    input  core_pkg::imm_t    imm,
    input  core_pkg::addr_t   pc,
    output logic              ack,
    output core_pkg::data_t   result,
    output core_pkg::flags_t  flags,
    output logic              branch_taken,
    output core_pkg::addr_t   branch_pc
);

    logic              commit;
    core_pkg::data_t   src_data;
    core_pkg::data_t   tgt_data;
    core_pkg::data_t   opnd_a;
    core_pkg::data_t   opnd_b;
    core_pkg::data_t   imm_s;
    logic              wr_en;
    core_pkg::data_t   wr_data;
    core_pkg::flags_t  flags_next;
    core_pkg::flags_t  flags_mask;

    exec_ctrl i_exec_ctrl (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .req    (req),
        .ack    (ack),
        .commit (commit)
    );

    exec_regfile #(
        .REG_COUNT (REG_COUNT)
    ) i_exec_regfile (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .src_idx  (src),
        .tgt_idx  (tgt), // Read and write index share the tgt field.
        .src_data (src_data),
        .tgt_data (tgt_data),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .commit   (commit)
    );

    exec_operand i_exec_operand (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .opc      (opc),
        .imm      (imm),
        .src_data (src_data),
        .tgt_data (tgt_data),
        .commit   (commit),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .imm_s    (imm_s)
    );

    exec_alu i_exec_alu (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .opc        (opc),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .commit     (commit),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .flags_next (flags_next),
        .flags_mask (flags_mask),
        .result     (result)
    );

    exec_cond i_exec_cond (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .opc          (opc),
        .cc           (cc),
        .pc           (pc),
        .opnd_a       (opnd_a),
        .imm_s        (imm_s),
        .flags_next   (flags_next),
        .flags_mask   (flags_mask),
        .commit       (commit),
        .flags        (flags),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

endmodule

// File: exec_tb_ref.svh
`ifndef EXEC_TB_REF_SVH
`define EXEC_TB_REF_SVH

// Shadow copy of the architectural state.
core_pkg::data_t  sh_regs [REG_COUNT];
core_pkg::flags_t sh_flags;
core_pkg::imm_t   sh_upper;

// Expected outputs of the instruction in flight.
core_pkg::data_t  exp_result;
core_pkg::flags_t exp_flags;
logic             exp_taken;
core_pkg::addr_t  exp_pc;

string cur_instr;

function automatic logic cond_holds(input isa_pkg::cond_e c, input core_pkg::flags_t f);
    logic z;
    logic n;
    logic cf;
    logic v;
    z  = f[isa_pkg::FLAG_Z];
    n  = f[isa_pkg::FLAG_N];
    cf = f[isa_pkg::FLAG_C];
    v  = f[isa_pkg::FLAG_V];
    case (c)
        isa_pkg::RA: return 1'b1;
        isa_pkg::EQ: return z;
        isa_pkg::NE: return !z;
        isa_pkg::LT: return n != v; // Signed less than.
        isa_pkg::GT: return !z && (n == v);
        isa_pkg::GE: return n == v;
        isa_pkg::LE: return z || (n != v);
        isa_pkg::BT: return cf;
        isa_pkg::AT: return !cf && !z;
        isa_pkg::BE: return cf || z;
        isa_pkg::AE: return !cf;
        default:     return 1'b0;
    endcase
endfunction

function automatic void ref_execute(input isa_pkg::opcode_e op, input isa_pkg::cond_e c,
        input logic [IDX_W-1:0] t, input logic [IDX_W-1:0] s,
        input core_pkg::imm_t im, input core_pkg::addr_t p);
    core_pkg::data_t  a;
    core_pkg::data_t  b;
    core_pkg::data_t  v;
    logic             wr;
    longint           sa;
    longint           sb;
    longint           swide;
    logic [63:0]      uwide;
    core_pkg::flags_t f;
    case (op)
        isa_pkg::MOVI, isa_pkg::ADDI, isa_pkg::CMPI: a = {sh_upper, im};
        isa_pkg::ADDIS, isa_pkg::BCCI:               a = {{16{im[15]}}, im};
        default:                                     a = sh_regs[s];
    endcase
    b  = sh_regs[t];
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    v  = '0;
    wr = 1'b0;
    f  = sh_flags;
    exp_taken = 1'b0;
    exp_pc    = '0;
    case (op)
        isa_pkg::MOV, isa_pkg::MOVI: begin
            v  = a;
            wr = 1'b1;
            f[isa_pkg::FLAG_Z] = (v == '0);
        end
        isa_pkg::ADD, isa_pkg::ADDI: begin
            uwide = 64'(b) + 64'(a);
            v  = uwide[31:0];
            wr = 1'b1;
            f[isa_pkg::FLAG_Z] = (v == '0);
            f[isa_pkg::FLAG_C] = uwide[32];
        end
        isa_pkg::SUB: begin
            v  = b - a;
            wr = 1'b1;
            f[isa_pkg::FLAG_Z] = (v == '0);
            f[isa_pkg::FLAG_C] = (b < a);
        end
        isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR: begin
            if (op == isa_pkg::AND) begin
                v = b & a;
            end else if (op == isa_pkg::OR) begin
                v = b | a;
            end else begin
                v = b ^ a;
            end
            wr = 1'b1;
            f[isa_pkg::FLAG_Z] = (v == '0);
        end
        isa_pkg::SHL, isa_pkg::SHR, isa_pkg::SHRS: begin
            if (a >= 32) begin
                v = '0;
            end else if (op == isa_pkg::SHL) begin
                v = b << a[4:0];
            end else if (op == isa_pkg::SHR) begin
                v = b >> a[4:0];
            end else begin
                v = $signed(b) >>> a[4:0];
            end
            wr = 1'b1;
            f[isa_pkg::FLAG_Z] = (v == '0);
            f[isa_pkg::FLAG_V] = (a >= 32);
            if (op == isa_pkg::SHRS) begin
                f[isa_pkg::FLAG_N] = v[31];
            end
        end
        isa_pkg::ADDS, isa_pkg::ADDIS, isa_pkg::SUBS: begin
            swide = (op == isa_pkg::SUBS) ? (sb - sa) : (sb + sa);
            v  = swide[31:0];
            wr = 1'b1;
            f[isa_pkg::FLAG_Z] = (v == '0);
            f[isa_pkg::FLAG_N] = v[31];
            f[isa_pkg::FLAG_V] = (swide != longint'($signed(v))); // Does not fit in 32 bits.
        end
        isa_pkg::CMP, isa_pkg::CMPI: begin
            f[isa_pkg::FLAG_Z] = (a == b);
            f[isa_pkg::FLAG_C] = (b < a);
        end
        isa_pkg::CMPS: begin
            swide = sb - sa;
            f[isa_pkg::FLAG_Z] = (a == b);
            f[isa_pkg::FLAG_N] = swide[31];
            f[isa_pkg::FLAG_V] = (swide != longint'($signed(swide[31:0])));
        end
        isa_pkg::JCC, isa_pkg::BCC, isa_pkg::BCCI: begin
            exp_taken = cond_holds(c, sh_flags);
            if (exp_taken) begin
                exp_pc = (op == isa_pkg::JCC) ? a : (p + a);
            end
        end
        isa_pkg::LUI: begin
            sh_upper = im;
        end
        default: begin
        end
    endcase
    if (wr) begin
        sh_regs[t] = v;
    end
    sh_flags   = f;
    exp_result = v;
    exp_flags  = f;
endfunction

task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s (instruction %s)", $time, msg, cur_instr);
    $display("** FAIL **");
    $fatal(1, "output mismatch");
endtask

task automatic check_result(input core_pkg::data_t got, input core_pkg::data_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("result is %h, expected %h", got, exp));
    end
endtask

task automatic check_flags(input core_pkg::flags_t got, input core_pkg::flags_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("flags VCNZ are %b, expected %b", got, exp));
    end
endtask

task automatic check_branch(input logic got_taken, input core_pkg::addr_t got_pc,
        input logic exp_tk, input core_pkg::addr_t exp_target);
    if ((got_taken !== exp_tk) || (got_pc !== exp_target)) begin
        report_mismatch($sformatf("branch is %b/%h, expected %b/%h",
            got_taken, got_pc, exp_tk, exp_target));
    end
endtask

`endif

// File: exec_tb.sv
`timescale 1ns/10ps

module exec_tb;

    localparam int REG_COUNT   = 16;
    localparam int IDX_W       = $clog2(REG_COUNT);
    localparam int ACK_TIMEOUT = 20; // Cycles.

    logic             iw_clk;
    logic             iw_rst;
    logic             req;
    isa_pkg::opcode_e opc;
    isa_pkg::cond_e   cc;
    logic [IDX_W-1:0] tgt;
    logic [IDX_W-1:0] src;
    core_pkg::imm_t   imm;
    core_pkg::addr_t  pc;
    logic             ack;
    core_pkg::data_t  result;
    core_pkg::flags_t flags;
    logic             branch_taken;
    core_pkg::addr_t  branch_pc;

    integer seed;
    int     issue_count;
    int     check_count;
    logic   checked;

    `include "exec_tb_ref.svh"

    exec_top #(
        .REG_COUNT (REG_COUNT)
    ) i_exec_top (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .req          (req),
        .opc          (opc),
        .cc           (cc),
        .tgt          (tgt),
        .src          (src),
        .imm          (imm),
        .pc           (pc),
        .ack          (ack),
        .result       (result),
        .flags        (flags),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    always #10 iw_clk = ~iw_clk;

    // Outputs hold from the commit edge until the next commit, so every ack cycle is checked.
    always @(negedge iw_clk) begin
        if (ack === 1'b1) begin
            check_result(result, exp_result);
            check_flags(flags, exp_flags);
            check_branch(branch_taken, branch_pc, exp_taken, exp_pc);
            if (!checked) begin
                check_count++;
            end
            checked = 1'b1;
        end else begin
            checked = 1'b0;
        end
    end

    task automatic report_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "handshake timeout");
    endtask

    // Called on a falling edge with ack low, returns on a falling edge with ack low.
    task automatic run_instr(input isa_pkg::opcode_e op, input isa_pkg::cond_e c,
            input int t, input int s, input core_pkg::imm_t im,
            input core_pkg::addr_t p, input int hold);
        logic [IDX_W-1:0] ti;
        logic [IDX_W-1:0] si;
        int               waited;
        ti = IDX_W'(t);
        si = IDX_W'(s);
        ref_execute(op, c, ti, si, im, p);
        cur_instr = $sformatf("%s r%0d r%0d imm %h", op.name(), ti, si, im);
        opc = op;
        cc  = c;
        tgt = ti;
        src = si;
        imm = im;
        pc  = p;
        req = 1'b1;
        issue_count++;
        waited = 0;
        while (ack !== 1'b1) begin
            @(negedge iw_clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                report_timeout("ack to rise");
            end
        end
        for (int i = 0; i < hold; i++) begin
            @(negedge iw_clk);
            if (ack !== 1'b1) begin
                report_mismatch("ack dropped while req was still high");
            end
        end
        req = 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            @(negedge iw_clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                report_timeout("ack to fall");
            end
        end
    endtask

    task automatic load_const(input int r, input core_pkg::data_t value);
        run_instr(isa_pkg::LUI, isa_pkg::RA, 0, 0, value[31:16], '0, 0);
        run_instr(isa_pkg::MOVI, isa_pkg::RA, r, 0, value[15:0], '0, 0);
    endtask

    // Every condition code with each branch kind; r12 and r13 hold target and offset.
    task automatic branch_sweep();
        isa_pkg::opcode_e br_ops [3];
        core_pkg::addr_t  base;
        br_ops = '{isa_pkg::JCC, isa_pkg::BCC, isa_pkg::BCCI};
        for (int ci = 0; ci < 11; ci++) begin
            for (int k = 0; k < 3; k++) begin
                base = $random(seed);
                run_instr(br_ops[k], isa_pkg::cond_e'(ci), 1, (k == 0) ? 12 : 13,
                    core_pkg::imm_t'($random(seed)), base, 0);
            end
        end
    endtask

    task automatic compare_then_branch(input isa_pkg::opcode_e op, input core_pkg::data_t b,
            input core_pkg::data_t a);
        load_const(10, b);
        load_const(11, a);
        run_instr(op, isa_pkg::RA, 10, 11, a[15:0], '0, 0);
        branch_sweep();
    endtask

    initial begin
        isa_pkg::opcode_e alu_ops [6];
        isa_pkg::opcode_e sh_ops [3];
        core_pkg::data_t  amt;
        iw_clk = 1'b0;
        iw_rst = 1'b1;
        req    = 1'b0;
        opc    = isa_pkg::NOP;
        cc     = isa_pkg::RA;
        tgt    = '0;
        src    = '0;
        imm    = '0;
        pc     = '0;
        seed        = 1932;
        issue_count = 0;
        check_count = 0;
        checked     = 1'b0;
        cur_instr   = "reset";
        sh_regs     = '{default: '0};
        sh_flags    = '0;
        sh_upper    = '0;
        exp_result  = '0;
        exp_flags   = '0;
        exp_taken   = 1'b0;
        exp_pc      = '0;
        alu_ops = '{isa_pkg::MOV, isa_pkg::ADD, isa_pkg::SUB,
                    isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR};
        sh_ops  = '{isa_pkg::SHL, isa_pkg::SHR, isa_pkg::SHRS};
        repeat (4) @(negedge iw_clk);
        iw_rst = 1'b0;
        @(negedge iw_clk);

        if (ack !== 1'b0) begin
            report_mismatch("ack is high after reset");
        end
        check_result(result, '0);
        check_flags(flags, '0);
        check_branch(branch_taken, branch_pc, 1'b0, '0);
        run_instr(isa_pkg::NOP, isa_pkg::RA, 3, 4, '0, '0, 0);
        for (int r = 0; r < REG_COUNT; r++) begin
            run_instr(isa_pkg::MOV, isa_pkg::RA, r, r, '0, '0, 0); // Reads back each register.
        end

        load_const(1, 32'hDEAD_BEEF);
        run_instr(isa_pkg::ADDI, isa_pkg::RA, 1, 0, 16'h0001, '0, 0);
        load_const(6, 32'hFFFF_FFFF);
        load_const(7, 32'h0000_0001);
        run_instr(isa_pkg::ADD, isa_pkg::RA, 6, 7, '0, '0, 0); // Carry out with zero.
        run_instr(isa_pkg::SUB, isa_pkg::RA, 7, 1, '0, '0, 0);
        for (int round = 0; round < 8; round++) begin
            for (int r = 2; r < 6; r++) begin
                load_const(r, $random(seed));
            end
            for (int k = 0; k < 6; k++) begin
                run_instr(alu_ops[k], isa_pkg::RA, 2 + ($random(seed) & 3),
                    2 + ($random(seed) & 3), '0, '0, 0);
            end
            run_instr(isa_pkg::SUB, isa_pkg::RA, 5, 5, '0, '0, 0);
        end

        load_const(6, 32'hFFFF_FFFF);
        run_instr(isa_pkg::ADD, isa_pkg::RA, 6, 7, '0, '0, 0); // Sets C ahead of signed ops.
        load_const(4, 32'h7FFF_FFFF);
        load_const(5, 32'h0000_0001);
        run_instr(isa_pkg::ADDS, isa_pkg::RA, 4, 5, '0, '0, 0);
        load_const(4, 32'h8000_0000);
        load_const(5, 32'hFFFF_FFFF);
        run_instr(isa_pkg::ADDS, isa_pkg::RA, 4, 5, '0, '0, 0);
        load_const(4, 32'h8000_0000);
        load_const(5, 32'h0000_0001);
        run_instr(isa_pkg::SUBS, isa_pkg::RA, 4, 5, '0, '0, 0);
        load_const(4, 32'h7FFF_FFFF);
        load_const(5, 32'hFFFF_FFFF);
        run_instr(isa_pkg::SUBS, isa_pkg::RA, 4, 5, '0, '0, 0);
        load_const(4, 32'h7FFF_FFF0);
        run_instr(isa_pkg::ADDIS, isa_pkg::RA, 4, 0, 16'h0010, '0, 0);
        load_const(4, 32'h8000_0000);
        run_instr(isa_pkg::ADDIS, isa_pkg::RA, 4, 0, 16'hFFFF, '0, 0);
        run_instr(isa_pkg::ADDIS, isa_pkg::RA, 4, 0, 16'h0001, '0, 0);

        for (int i = 0; i < 36; i++) begin
            amt = (i < 34) ? core_pkg::data_t'(i) : ((i == 34) ? 32'h100 : 32'hFFFF_FFFF);
            for (int k = 0; k < 3; k++) begin
                load_const(8, $random(seed));
                load_const(9, amt);
                run_instr(sh_ops[k], isa_pkg::RA, 8, 9, '0, '0, 0);
            end
        end

        load_const(12, $random(seed));
        load_const(13, $random(seed));
        compare_then_branch(isa_pkg::CMP, $random(seed), $random(seed));
        compare_then_branch(isa_pkg::CMP, 32'h1234_5678, 32'h1234_5678);
        compare_then_branch(isa_pkg::CMP, 32'h0000_0005, 32'h0000_0009);
        compare_then_branch(isa_pkg::CMPI, 32'h0000_0009, 32'h0000_0005);
        compare_then_branch(isa_pkg::CMPS, 32'hFFFF_FFFB, 32'h0000_0003);
        compare_then_branch(isa_pkg::CMPS, 32'h8000_0000, 32'h0000_0001);
        compare_then_branch(isa_pkg::CMPS, 32'h0000_0007, 32'hFFFF_FFFE);

        load_const(14, $random(seed));
        load_const(15, $random(seed));
        run_instr(isa_pkg::ADD, isa_pkg::RA, 14, 15, '0, '0, 6);
        run_instr(isa_pkg::MOV, isa_pkg::RA, 0, 14, '0, '0, 0);
        run_instr(isa_pkg::ADD, isa_pkg::RA, 14, 15, '0, '0, 3);
        run_instr(isa_pkg::MOV, isa_pkg::RA, 0, 14, '0, '0, 0);

        @(negedge iw_clk);
        if (check_count == issue_count) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Only %0d of %0d instructions were checked", check_count, issue_count);
            $display("** FAIL **");
            $fatal(1, "missing checks");
        end
    end

endmodule

// File: src.f
+incdir+.
isa_pkg.sv
core_pkg.sv
exec_ctrl.sv
exec_regfile.sv
exec_operand.sv
exec_alu.sv
exec_cond.sv
exec_top.sv
exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module exec_tb -o exec_sim \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/exec_sim 2>&1)
echo "$out"

echo "$out" | grep -qxF '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
